//--- include/mul_defines.svh
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// Operand and product widths
`define MUL_WIDTH 32
`define PROD_WIDTH 64

// Radix-4 groups over the 33-bit extended multiplier
`define BOOTH_GROUPS 17

// Edges from input strobe to output pulse
`define MUL_LATENCY 4

`endif

//--- rtl/boothPkg.sv
package boothPkg;

    // Bit positions inside a Booth digit
    localparam int DIGIT_ONE_BIT = 0;
    localparam int DIGIT_TWO_BIT = 1;
    localparam int DIGIT_NEG_BIT = 2;

    // Encoded as {negative, magnitude-two, magnitude-one}
    typedef enum logic [2:0] {
        DIGIT_ZERO = 3'b000,
        DIGIT_POS1 = 3'b001,
        DIGIT_POS2 = 3'b010,
        DIGIT_NEG1 = 3'b101,
        DIGIT_NEG2 = 3'b110
    } boothDigitT;

    // Group is {b[2i+1], b[2i], b[2i-1]}
    function automatic boothDigitT boothRecode(input logic [2:0] grp);
        boothDigitT digit;
        case (grp)
            3'b001,
            3'b010:  digit = DIGIT_POS1;
            3'b011:  digit = DIGIT_POS2;
            3'b100:  digit = DIGIT_NEG2;
            3'b101,
            3'b110:  digit = DIGIT_NEG1;
            default: digit = DIGIT_ZERO; // 000 and 111
        endcase
        return digit;
    endfunction

endpackage

//--- rtl/mulPipePkg.sv
`include "mul_defines.svh"

package mulPipePkg;

    // Partial-product stage
    typedef struct packed {
        logic [`BOOTH_GROUPS-1:0][`PROD_WIDTH-1:0] rows; // Shifted, possibly complemented
        logic [`BOOTH_GROUPS-1:0]                  neg;  // Plus-one per negated row
    } ppStageT;

    // Carry-save stage
    typedef struct packed {
        logic [`PROD_WIDTH-1:0] sum;
        logic [`PROD_WIDTH-1:0] carry;
    } csStageT;

endpackage

//--- rtl/operandIf.sv
`include "mul_defines.svh"

interface operandIf;

    logic                  valid;
    logic [`MUL_WIDTH-1:0] multiplicand;
    logic [`MUL_WIDTH-1:0] multiplier;
    logic                  isSigned;

    modport source (
        output valid,
        output multiplicand,
        output multiplier,
        output isSigned
    );

    modport sink (
        input valid,
        input multiplicand,
        input multiplier,
        input isSigned
    );

endinterface

//--- rtl/operandLatch.sv
`include "mul_defines.svh"

module operandLatch (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  inValid,
    input  logic [`MUL_WIDTH-1:0] op1,
    input  logic [`MUL_WIDTH-1:0] op2,
    input  logic                  isSigned,
    operandIf.source              opBus
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            opBus.valid <= 1'b0;
        end else begin
            opBus.valid <= inValid; // One-cycle level per strobe
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            opBus.multiplicand <= '0;
            opBus.multiplier   <= '0;
            opBus.isSigned     <= 1'b0;
        end else if (inValid) begin
            opBus.multiplicand <= op1;
            opBus.multiplier   <= op2;
            opBus.isSigned     <= isSigned;
        end
    end

endmodule

//--- rtl/boothEncoder.sv
`include "mul_defines.svh"

module boothEncoder (
    operandIf.sink              opBus,
    output logic                ppValid,
    output mulPipePkg::ppStageT ppStage
);

    import boothPkg::*;
    import mulPipePkg::*;

    logic                    mcandSign;
    logic                    mplierSign;
    logic [`PROD_WIDTH-1:0]  mcandExt;
    logic [`MUL_WIDTH+2:0]   mplierExt;
    ppStageT                 ppNext;

    assign mcandSign  = opBus.isSigned & opBus.multiplicand[`MUL_WIDTH-1];
    assign mplierSign = opBus.isSigned & opBus.multiplier[`MUL_WIDTH-1];

    assign mcandExt = {{(`PROD_WIDTH - `MUL_WIDTH){mcandSign}}, opBus.multiplicand};

    // Two extension bits on top, implicit zero below bit 0
    assign mplierExt = {{2{mplierSign}}, opBus.multiplier, 1'b0};

    for (genvar i = 0; i < `BOOTH_GROUPS; i++) begin : gGroup
        boothDigitT             digit;
        logic [`PROD_WIDTH-1:0] mag;

        assign digit = boothRecode(mplierExt[2*i+2 -: 3]);

        assign mag = digit[DIGIT_TWO_BIT] ? (mcandExt << 1) :
                     digit[DIGIT_ONE_BIT] ? mcandExt : '0;

        // Complement before shift so the plus-one sits at bit 2i
        assign ppNext.rows[i] = (digit[DIGIT_NEG_BIT] ? ~mag : mag) << (2 * i);
        assign ppNext.neg[i]  = digit[DIGIT_NEG_BIT];
    end

    assign ppStage = ppNext;
    assign ppValid = opBus.valid;

endmodule

//--- rtl/pipeReg.sv
module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outData <= '0;
        end else if (inValid) begin
            outData <= inData; // Hold when idle
        end
    end

endmodule

//--- rtl/csaTree.sv
`include "mul_defines.svh"

module csaTree (
    input  mulPipePkg::ppStageT ppStage,
    output mulPipePkg::csStageT csStage
);

    // Row count after a number of 3:2 layers
    function automatic int rowsAt(input int start, input int layer);
        int n;
        n = start;
        for (int l = 0; l < layer; l++) begin
            n = 2 * (n / 3) + (n % 3);
        end
        return n;
    endfunction

    function automatic int layersNeeded(input int start);
        int n;
        int cnt;
        n   = start;
        cnt = 0;
        while (n > 2) begin
            n   = 2 * (n / 3) + (n % 3);
            cnt = cnt + 1;
        end
        return cnt;
    endfunction

    localparam int ROWS   = `BOOTH_GROUPS + 1; // Partial products plus correction
    localparam int LAYERS = layersNeeded(ROWS);

    logic [`PROD_WIDTH-1:0] corrRow;
    logic [`PROD_WIDTH-1:0] rowVec [LAYERS+1][ROWS];

    always_comb begin
        corrRow = '0;
        for (int i = 0; i < `BOOTH_GROUPS; i++) begin
            corrRow[2*i] = ppStage.neg[i];
        end
    end

    for (genvar j = 0; j < `BOOTH_GROUPS; j++) begin : gLoad
        assign rowVec[0][j] = ppStage.rows[j];
    end
    assign rowVec[0][ROWS-1] = corrRow;

    for (genvar l = 0; l < LAYERS; l++) begin : gLayer
        localparam int N    = rowsAt(ROWS, l);
        localparam int G    = N / 3;
        localparam int NEXT = rowsAt(ROWS, l + 1);

        for (genvar j = 0; j < ROWS; j++) begin : gRow
            localparam int K = j / 2;
            if (j < 2 * G && j % 2 == 0) begin : gSum
                assign rowVec[l+1][j] = rowVec[l][3*K] ^ rowVec[l][3*K+1] ^ rowVec[l][3*K+2];
            end else if (j < 2 * G) begin : gCarry
                assign rowVec[l+1][j] = ((rowVec[l][3*K] & rowVec[l][3*K+1]) |
                                         (rowVec[l][3*K] & rowVec[l][3*K+2]) |
                                         (rowVec[l][3*K+1] & rowVec[l][3*K+2])) << 1;
            end else if (j < NEXT) begin : gPass
                assign rowVec[l+1][j] = rowVec[l][j+G]; // Leftover rows skip the layer
            end else begin : gIdle
                assign rowVec[l+1][j] = '0;
            end
        end
    end

    assign csStage.sum   = rowVec[LAYERS][0];
    assign csStage.carry = rowVec[LAYERS][1];

endmodule

//--- rtl/productOut.sv
`include "mul_defines.svh"

module productOut (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   inValid,
    input  mulPipePkg::csStageT    csStage,
    output logic                   outValid,
    output logic [`PROD_WIDTH-1:0] product
);

    logic [`PROD_WIDTH-1:0] total;

    // Final carry-propagate add, wraps at 64 bits
    assign total = csStage.sum + csStage.carry;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid; // Single-cycle pulse
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            product <= '0;
        end else if (inValid) begin
            product <= total;
        end
    end

endmodule

//--- rtl/boothMul32.sv
`include "mul_defines.svh"

module boothMul32 (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   inValid,
    input  logic [`MUL_WIDTH-1:0]  op1,
    input  logic [`MUL_WIDTH-1:0]  op2,
    input  logic                   isSigned,
    output logic                   outValid,
    output logic [`PROD_WIDTH-1:0] product
);

    import mulPipePkg::*;

    logic    ppValid;
    ppStageT ppStage;
    logic    ppRegValid;
    ppStageT ppReg;
    csStageT csStage;
    logic    csRegValid;
    csStageT csReg;

    operandIf opBus ();

    operandLatch uLatch (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .op1      (op1),
        .op2      (op2),
        .isSigned (isSigned),
        .opBus    (opBus.source)
    );

    boothEncoder uEncoder (
        .opBus   (opBus.sink),
        .ppValid (ppValid),
        .ppStage (ppStage)
    );

    pipeReg #(.payloadT(ppStageT)) uPpReg ( // Edge 2
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (ppValid),
        .inData   (ppStage),
        .outValid (ppRegValid),
        .outData  (ppReg)
    );

    csaTree uTree (
        .ppStage (ppReg),
        .csStage (csStage)
    );

    pipeReg #(.payloadT(csStageT)) uCsReg ( // Edge 3
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (ppRegValid),
        .inData   (csStage),
        .outValid (csRegValid),
        .outData  (csReg)
    );

    productOut uOut (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (csRegValid),
        .csStage  (csReg),
        .outValid (outValid),
        .product  (product)
    );

endmodule

//--- tests/boothMul32_props.sv
`include "mul_defines.svh"

module boothMul32_props (
    input logic clk,
    input logic arstN,
    input logic inValid,
    input logic outValid
);

    timeunit 1ns;
    timeprecision 1ps;

    int sinceReset; // Saturates once the pipeline has filled
    int inFlight;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sinceReset <= 0;
        end else if (sinceReset < `MUL_LATENCY) begin
            sinceReset <= sinceReset + 1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            inFlight <= 0;
        end else begin
            inFlight <= inFlight + (inValid ? 1 : 0) - (outValid ? 1 : 0);
        end
    end

    resetQuiet: assert property (@(posedge clk) !arstN |-> !outValid)
        else $error("outValid high while reset is asserted");

    latencyMatch: assert property (@(posedge clk) disable iff (!arstN)
        (sinceReset == `MUL_LATENCY) |-> (outValid == $past(inValid, `MUL_LATENCY)))
        else $error("outValid does not follow inValid by the pipeline latency");

    noOrphanPulse: assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> (inFlight > 0))
        else $error("outValid pulse without an earlier strobe");

    // At most one operation per stage
    inFlightBound: assert property (@(posedge clk) disable iff (!arstN)
        inFlight <= `MUL_LATENCY)
        else $error("More operations in flight than pipeline stages");

endmodule

bind boothMul32 boothMul32_props uProps (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (inValid),
    .outValid (outValid)
);

//--- tests/boothMul32_tb.sv
`include "mul_defines.svh"

module boothMul32_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int STREAM_OPS   = 200;
    localparam int GAP_OPS      = 60;
    localparam int MAX_GAP      = 4;
    localparam int DRAIN_LIMIT  = `MUL_LATENCY + 4;
    localparam int DRAIN_CYCLES = 1 + DRAIN_LIMIT + 2;
    localparam int WATCHDOG_CYCLES = (1 + RESET_CYCLES + 8)
                                   + (7 + DRAIN_CYCLES)
                                   + (6 + DRAIN_CYCLES)
                                   + (STREAM_OPS + DRAIN_CYCLES)
                                   + (GAP_OPS * (MAX_GAP + 1) + DRAIN_CYCLES)
                                   + 50; // Margin

    logic                   clk;
    logic                   arstN;
    logic                   inValid;
    logic [`MUL_WIDTH-1:0]  op1;
    logic [`MUL_WIDTH-1:0]  op2;
    logic                   isSigned;
    logic                   outValid;
    logic [`PROD_WIDTH-1:0] product;

    logic [31:0]            lcgState;
    int                     cycleCnt;
    int                     errorCount;
    int                     testsRun;
    int                     testsFailed;
    int                     pulseCount;
    logic [`PROD_WIDTH-1:0] expProd [$];
    int                     expCycle [$];

    boothMul32 dut (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .op1      (op1),
        .op2      (op2),
        .isSigned (isSigned),
        .outValid (outValid),
        .product  (product)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Full 64-bit product of the extended operands
    function automatic logic [`PROD_WIDTH-1:0] refProduct(input logic [`MUL_WIDTH-1:0] a,
                                                          input logic [`MUL_WIDTH-1:0] b,
                                                          input logic              s);
        logic [`PROD_WIDTH-1:0] ea;
        logic [`PROD_WIDTH-1:0] eb;
        ea = {{(`PROD_WIDTH - `MUL_WIDTH){s & a[`MUL_WIDTH-1]}}, a};
        eb = {{(`PROD_WIDTH - `MUL_WIDTH){s & b[`MUL_WIDTH-1]}}, b};
        return ea * eb;
    endfunction

    task automatic compareValue(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errorCount++;
        end
    endtask

    // Checks every pulse against the oldest pending operation
    always @(negedge clk) begin
        if (outValid === 1'b1) begin
            pulseCount++;
            if (expProd.size() == 0) begin
                $display("Unexpected outValid pulse with no operation in flight");
                errorCount++;
            end else begin
                compareValue("product", product, expProd.pop_front());
                compareValue("outValid cycle", 64'(cycleCnt), 64'(expCycle.pop_front()));
            end
        end
    end

    task automatic issueOp(input logic [31:0] a, input logic [31:0] b, input logic s);
        @(negedge clk);
        inValid  = 1'b1;
        op1      = a;
        op2      = b;
        isSigned = s;
        expProd.push_back(refProduct(a, b, s));
        expCycle.push_back(cycleCnt + `MUL_LATENCY); // Sampled on the next edge
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            inValid = 1'b0;
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        idleCycles(1);
        while (expProd.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (expProd.size() != 0) begin
            $display("Timed out waiting for %0d pending products", expProd.size());
            errorCount++;
            expProd.delete();
            expCycle.delete();
        end
        idleCycles(2); // Catch stray pulses
    endtask

    task automatic finishTest(input string name, input int errBefore);
        testsRun++;
        if (errorCount == errBefore) begin
            $display("%s: passed", name);
        end else begin
            testsFailed++;
            $display("%s: %0d errors", name, errorCount - errBefore);
        end
    endtask

    task automatic testReset();
        int errBefore;
        errBefore = errorCount;
        @(negedge clk);
        arstN = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compareValue("outValid", 64'(outValid), 64'h0);
        end
        arstN = 1'b1;
        repeat (8) begin
            @(negedge clk);
            compareValue("outValid", 64'(outValid), 64'h0);
        end
        finishTest("reset", errBefore);
    endtask

    task automatic testSignedCorners();
        int errBefore;
        errBefore = errorCount;
        issueOp(32'h0000_0000, 32'h1234_5678, 1'b1);
        issueOp(32'h0000_0001, 32'hFEDC_BA98, 1'b1);
        issueOp(32'hFFFF_FFFF, 32'h7654_3210, 1'b1);
        issueOp(32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b1);
        issueOp(32'h8000_0000, 32'h8000_0000, 1'b1);
        issueOp(32'h8000_0000, 32'hFFFF_FFFF, 1'b1);
        issueOp(32'h7FFF_FFFF, 32'h8000_0000, 1'b1);
        waitDrain();
        finishTest("signed corners", errBefore);
    endtask

    task automatic testUnsignedCorners();
        int errBefore;
        errBefore = errorCount;
        issueOp(32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0);
        issueOp(32'hFFFF_FFFF, 32'h0000_0001, 1'b0);
        issueOp(32'hAAAA_AAAA, 32'h5555_5555, 1'b0);
        issueOp(32'h5555_5555, 32'hAAAA_AAAA, 1'b0);
        issueOp(32'hAAAA_AAAA, 32'hAAAA_AAAA, 1'b0);
        issueOp(32'h8000_0000, 32'hFFFF_FFFF, 1'b0); // Top group zero-extended
        waitDrain();
        finishTest("unsigned corners", errBefore);
    endtask

    task automatic testStreaming();
        int          errBefore;
        int          pulsesBefore;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] mode;
        errBefore    = errorCount;
        pulsesBefore = pulseCount;
        for (int i = 0; i < STREAM_OPS; i++) begin
            a    = lcgNext();
            b    = lcgNext();
            mode = lcgNext();
            issueOp(a, b, mode[16]);
        end
        waitDrain();
        compareValue("outValid pulse count", 64'(pulseCount - pulsesBefore), 64'(STREAM_OPS));
        finishTest("streaming", errBefore);
    endtask

    task automatic testGaps();
        int          errBefore;
        int          pulsesBefore;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] mode;
        logic [31:0] gap;
        errBefore    = errorCount;
        pulsesBefore = pulseCount;
        for (int i = 0; i < GAP_OPS; i++) begin
            a    = lcgNext();
            b    = lcgNext();
            mode = lcgNext();
            gap  = lcgNext() % 32'(MAX_GAP + 1);
            issueOp(a, b, mode[16]);
            idleCycles(int'(gap));
        end
        waitDrain();
        compareValue("outValid pulse count", 64'(pulseCount - pulsesBefore), 64'(GAP_OPS));
        finishTest("gaps", errBefore);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        arstN       = 1'b1; // Asserted on the first falling edge
        inValid     = 1'b0;
        op1         = '0;
        op2         = '0;
        isSigned    = 1'b0;
        lcgState    = 32'h5ae;
        cycleCnt    = 0;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        pulseCount  = 0;

        testReset();
        testSignedCorners();
        testUnsignedCorners();
        testStreaming();
        testGaps();

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
rtl/boothPkg.sv
rtl/mulPipePkg.sv
rtl/operandIf.sv
rtl/operandLatch.sv
rtl/boothEncoder.sv
rtl/pipeReg.sv
rtl/csaTree.sv
rtl/productOut.sv
rtl/boothMul32.sv
tests/boothMul32_props.sv
tests/boothMul32_tb.sv

//--- Makefile
TOP = boothMul32_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
